// File: testbench/dcache_vectors.txt
# op addr data strobe expected, all hex
# strobe 00 reads, expected is checked on reads only
r 80000008 0000000000000000 00 0000000000000000
r 80000008 0000000000000000 00 0000000000000000
w 80000008 1122334455667788 0f 0000000000000000
r 80000008 0000000000000000 00 0000000055667788
w 80000008 aabbccddeeff0011 f0 0000000000000000
r 80000008 0000000000000000 00 aabbccdd55667788
w 80000008 0000000000009900 02 0000000000000000
r 80000008 0000000000000000 00 aabbccdd55669988
w 80000008 123456789abcdef0 81 0000000000000000
r 80000008 0000000000000000 00 12bbccdd556699f0
w 80000008 ffffffffffffffff 3c 0000000000000000
r 80000008 0000000000000000 00 12bbffffffff99f0
r 80000208 0000000000000000 00 0000000000000000
w 80000208 0badc0de0badc0de ff 0000000000000000
r 80000008 0000000000000000 00 12bbffffffff99f0
r 80000208 0000000000000000 00 0badc0de0badc0de
w 80000000 1111111111111111 ff 0000000000000000
r 80000200 0000000000000000 00 0000000000000000
r 80000000 0000000000000000 00 1111111111111111
r 80000008 0000000000000000 00 12bbffffffff99f0
w 80000418 c0c0c0c0c0c0c0c0 ff 0000000000000000
r 80000018 0000000000000000 00 0000000000000000
r 80000418 0000000000000000 00 c0c0c0c0c0c0c0c0
r 10000800 0000000000000000 00 0000000000000000
w 10000800 5a5a5a5aa5a5a5a5 ff 0000000000000000
r 10000800 0000000000000000 00 5a5a5a5aa5a5a5a5
w 10000808 0123456789abcdef 0f 0000000000000000
r 10000808 0000000000000000 00 0000000089abcdef
r 10000810 0000000000000000 00 0000000000000000
r 00000ff8 0000000000000000 00 0000000000000000
w 00000ff8 fedcba9876543210 ff 0000000000000000
r 00000ff8 0000000000000000 00 fedcba9876543210
r 80000008 0000000000000000 00 12bbffffffff99f0
w 80000020 1010101010101010 ff 0000000000000000
w 80000028 2020202020202020 ff 0000000000000000
w 80000030 3030303030303030 ff 0000000000000000
w 80000038 4040404040404040 ff 0000000000000000
r 80000020 0000000000000000 00 1010101010101010
r 80000028 0000000000000000 00 2020202020202020
r 80000030 0000000000000000 00 3030303030303030
r 80000038 0000000000000000 00 4040404040404040
w 80000088 4444444444444444 ff 0000000000000000
w 80000110 8888888888888888 ff 0000000000000000
w 80000198 cccccccccccccccc ff 0000000000000000
w 800003e0 ffffffff00000000 ff 0000000000000000
r 80000030 0000000000000000 00 3030303030303030
r 80000088 0000000000000000 00 4444444444444444
r 80000110 0000000000000000 00 8888888888888888
r 80000198 0000000000000000 00 cccccccccccccccc
r 800003e0 0000000000000000 00 ffffffff00000000
r 80000008 0000000000000000 00 12bbffffffff99f0

// File: all.f
rtl/dcache_pkg.sv
rtl/sp_ram.sv
rtl/dcache.sv
rtl/main_memory.sv
rtl/dcache_top.sv
testbench/tb_clock.sv
testbench/dcache_properties.sv
testbench/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - files:
      - rtl/dcache_pkg.sv
      - rtl/sp_ram.sv
      - rtl/dcache.sv
      - rtl/main_memory.sv
      - rtl/dcache_top.sv
  - target: simulation
    files:
      - testbench/tb_clock.sv
      - testbench/dcache_properties.sv
      - testbench/dcache_tb.sv

// File: testbench/dcache_tb.sv
`timescale 1ns/100ps

module dcache_tb import dcache_pkg::*; ();
	// budget per access, covers writeback plus refill plus gap
	localparam int cycles_per_vector = 40;

	logic clk;
	logic reset;
	logic dreq_valid;
	logic [addr_width-1:0] dreq_addr;
	logic [strobe_width-1:0] dreq_strobe;
	logic [data_width-1:0] dreq_data;
	logic dresp_data_ok;
	logic [data_width-1:0] dresp_data;

	// one entry per access
	bit vec_is_read [$];
	logic [addr_width-1:0] vec_addr [$];
	logic [data_width-1:0] vec_data [$];
	logic [strobe_width-1:0] vec_strobe [$];
	logic [data_width-1:0] vec_expected [$];
	bit loaded;

	tb_clock clock0 (
		.clk,
		.reset
	);

	dcache_top dut0 (
		.clk,
		.reset,
		.dreq_valid,
		.dreq_addr,
		.dreq_strobe,
		.dreq_data,
		.dresp_data_ok,
		.dresp_data
	);

	task automatic check_data(input string signal_name, input logic [data_width-1:0] expected,
			input logic [data_width-1:0] actual);
		if (actual !== expected) begin
			$display("Error at %0t ns: %s expected %h, got %h", $time, signal_name,
				expected, actual);
			$display("RESULT: FAIL");
			$fatal(1, "read data mismatch");
		end
	endtask

	task automatic check_state(input string signal_name, input cache_state_t expected,
			input cache_state_t actual);
		if (actual !== expected) begin
			$display("Error at %0t ns: %s expected %s, got %s", $time, signal_name,
				expected.name(), actual.name());
			$display("RESULT: FAIL");
			$fatal(1, "cache state mismatch");
		end
	endtask

	// op token first, a lone # starts a comment line
	task automatic load_vectors();
		int fd;
		int code;
		logic [63:0] op_token;
		logic [8*200-1:0] skipped;
		logic [addr_width-1:0] addr;
		logic [data_width-1:0] data;
		logic [strobe_width-1:0] strobe;
		logic [data_width-1:0] expected;
		fd = $fopen("testbench/dcache_vectors.txt", "r");
		if (fd == 0) begin
			$display("Could not open testbench/dcache_vectors.txt");
			$display("RESULT: FAIL");
			$fatal(1, "vector file missing");
		end
		while (!$feof(fd)) begin
			code = $fscanf(fd, "%s", op_token);
			if (code == 1 && op_token == "#") begin
				code = $fgets(skipped, fd);
			end else if (code == 1) begin
				code = $fscanf(fd, "%h %h %h %h", addr, data, strobe, expected);
				if (code != 4 || (op_token != "r" && op_token != "w")) begin
					$display("Malformed line in the vector file after %0d accesses",
						vec_addr.size());
					$display("RESULT: FAIL");
					$fatal(1, "bad vector line");
				end
				vec_is_read.push_back(op_token == "r");
				vec_addr.push_back(addr);
				vec_data.push_back(data);
				vec_strobe.push_back(strobe);
				vec_expected.push_back(expected);
			end
		end
		$fclose(fd);
	endtask

	// request goes out on a falling edge and stays until data_ok
	task automatic run_access(input int idx, output logic [data_width-1:0] read_data);
		@(negedge clk);
		dreq_valid = 1'b1;
		dreq_addr = vec_addr[idx];
		dreq_strobe = vec_strobe[idx];
		dreq_data = vec_data[idx];
		@(negedge clk);
		while (dresp_data_ok !== 1'b1) begin
			@(negedge clk);
		end
		// still held through the next rising edge, where a write hit lands
		read_data = dresp_data;
	endtask

	initial begin
		int seed_value;
		int gap;
		logic [data_width-1:0] read_data;
		dreq_valid = 1'b0;
		dreq_addr = '0;
		dreq_strobe = '0;
		dreq_data = '0;
		seed_value = $urandom(32'hde1b_670f);
		load_vectors();
		loaded = 1'b1;
		wait (reset === 1'b0);
		for (int i = 0; i < vec_addr.size(); i++) begin
			// idle gap of 0 to 3 cycles
			gap = $urandom % 4;
			repeat (gap) begin
				@(negedge clk);
				dreq_valid = 1'b0;
			end
			run_access(i, read_data);
			if (vec_is_read[i]) begin
				check_data("dresp_data", vec_expected[i], read_data);
			end
		end
		@(negedge clk);
		dreq_valid = 1'b0;
		@(negedge clk);
		check_state("dut0.cache0.state", idle, dut0.cache0.state);
		$display("RESULT: PASS");
		$finish;
	end

	// a failed bus assertion in the cache ends the run
	initial begin
		wait (dut0.cache0.props0.failures != 0);
		$display("A bus protocol assertion failed inside dut0.cache0");
		$display("RESULT: FAIL");
		$fatal(1, "assertion failure");
	end

	// watchdog, scaled to the number of accesses
	initial begin
		wait (loaded);
		repeat (vec_addr.size() * cycles_per_vector) @(posedge clk);
		$display("Timeout: data_ok never came within %0d cycles",
			vec_addr.size() * cycles_per_vector);
		$display("RESULT: FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

// File: testbench/dcache_properties.sv
`timescale 1ns/100ps

module dcache_properties import dcache_pkg::*; (
	input logic clk,
	input logic reset,
	input cache_state_t state,
	input logic creq_valid,
	input logic [addr_width-1:0] creq_addr,
	input logic [len_width-1:0] creq_len,
	input logic cresp_ready,
	input logic cresp_last,
	input logic dresp_data_ok
);
	// failed assertions so far
	int failures = 0;

	// request drops only on the cycle after the beat with last
	release_after_last: assert property (@(posedge clk) disable iff (reset)
		$fell(creq_valid) |-> $past(cresp_ready && cresp_last))
		else begin
			$error("memory request dropped before the last beat");
			failures++;
		end

	// address and length hold until the beat with last
	burst_stable: assert property (@(posedge clk) disable iff (reset)
		creq_valid && !(cresp_ready && cresp_last)
		|=> $stable(creq_addr) && $stable(creq_len))
		else begin
			$error("burst address or length changed before the last beat");
			failures++;
		end

	// cpu gets nothing in the middle of a line transfer
	no_ok_in_transfer: assert property (@(posedge clk) disable iff (reset)
		(state == fetch || state == writeback) |-> !dresp_data_ok)
		else begin
			$error("data_ok raised during a refill or writeback");
			failures++;
		end

endmodule

bind dcache dcache_properties props0 (
	.clk(clk),
	.reset(reset),
	.state(state),
	.creq_valid(creq_valid),
	.creq_addr(creq_addr),
	.creq_len(creq_len),
	.cresp_ready(cresp_ready),
	.cresp_last(cresp_last),
	.dresp_data_ok(dresp_data_ok)
);

// File: testbench/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
	output logic clk,
	output logic reset
);
	// 100 ns period
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// reset held over two rising edges, released on a falling edge
	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

// File: rtl/dcache_top.sv
`timescale 1ns/100ps

module dcache_top import dcache_pkg::*; (
	input logic clk,
	input logic reset,
	// cpu bus
	input logic dreq_valid,
	input logic [addr_width-1:0] dreq_addr,
	input logic [strobe_width-1:0] dreq_strobe,
	input logic [data_width-1:0] dreq_data,
	output logic dresp_data_ok,
	output logic [data_width-1:0] dresp_data
);
	// burst bus between cache and memory
	logic creq_valid;
	logic creq_is_write;
	logic [addr_width-1:0] creq_addr;
	logic [len_width-1:0] creq_len;
	logic [strobe_width-1:0] creq_strobe;
	logic [data_width-1:0] creq_data;
	logic cresp_ready;
	logic cresp_last;
	logic [data_width-1:0] cresp_data;

	dcache cache0 (
		.clk,
		.reset,
		.dreq_valid,
		.dreq_addr,
		.dreq_strobe,
		.dreq_data,
		.dresp_data_ok,
		.dresp_data,
		.creq_valid,
		.creq_is_write,
		.creq_addr,
		.creq_len,
		.creq_strobe,
		.creq_data,
		.cresp_ready,
		.cresp_last,
		.cresp_data
	);

	main_memory mem0 (
		.clk,
		.reset,
		.creq_valid,
		.creq_is_write,
		.creq_addr,
		.creq_len,
		.creq_strobe,
		.creq_data,
		.cresp_ready,
		.cresp_last,
		.cresp_data
	);

endmodule

// File: rtl/main_memory.sv
`timescale 1ns/100ps

module main_memory import dcache_pkg::*; (
	input logic clk,
	input logic reset,
	// burst request from the cache
	input logic creq_valid,
	input logic creq_is_write,
	input logic [addr_width-1:0] creq_addr,
	input logic [len_width-1:0] creq_len,
	input logic [strobe_width-1:0] creq_strobe,
	input logic [data_width-1:0] creq_data,
	// beat response
	output logic cresp_ready,
	output logic cresp_last,
	output logic [data_width-1:0] cresp_data
);
	logic active;
	logic [len_width-1:0] beat;
	logic [mem_word_bits-1:0] word_addr;
	logic [strobe_width-1:0] mem_wen;
	logic [data_width-1:0] mem_rdata;

	// burst control
	// first cycle with valid is the wait state
	// a new burst may follow last directly without valid dropping
	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			beat <= '0;
		end else if (active) begin
			if (cresp_last) begin
				active <= 1'b0;
				beat <= '0;
			end else begin
				beat <= beat + 1'b1;
			end
		end else if (creq_valid) begin
			active <= 1'b1;
		end
	end

	// every active cycle is a beat
	assign cresp_ready = active;
	// beats count from one, so the final beat is number creq_len
	assign cresp_last = active && (len_width'(beat + 1'b1) == creq_len);

	// incrementing word address on the low address bits
	// upper bits ignored, so regions alias
	assign word_addr = creq_addr[align_bits +: mem_word_bits] + mem_word_bits'(beat);

	// store only on a write beat
	assign mem_wen = (active && creq_is_write) ? creq_strobe : '0;

	sp_ram #(
		.addr_bits(mem_word_bits),
		.data_bits(data_width),
		.read_latency(0)
	) mem_array (
		.clk,
		.addr(word_addr),
		.wen(mem_wen),
		.wdata(creq_data),
		.rdata(mem_rdata)
	);

	// read data straight from the current beat address
	assign cresp_data = mem_rdata;

endmodule

// File: rtl/dcache.sv
`timescale 1ns/100ps

module dcache import dcache_pkg::*; (
	input logic clk,
	input logic reset,
	// cpu side
	input logic dreq_valid,
	input logic [addr_width-1:0] dreq_addr,
	input logic [strobe_width-1:0] dreq_strobe,
	input logic [data_width-1:0] dreq_data,
	output logic dresp_data_ok,
	output logic [data_width-1:0] dresp_data,
	// memory side, burst bus
	output logic creq_valid,
	output logic creq_is_write,
	output logic [addr_width-1:0] creq_addr,
	output logic [len_width-1:0] creq_len,
	output logic [strobe_width-1:0] creq_strobe,
	output logic [data_width-1:0] creq_data,
	input logic cresp_ready,
	input logic cresp_last,
	input logic [data_width-1:0] cresp_data
);
	logic [tag_bits-1:0] req_tag;
	logic [index_bits-1:0] req_index;
	logic [word_bits-1:0] req_word;
	logic is_uncached;

	cache_state_t state, state_nxt;
	logic [word_bits-1:0] beat, beat_nxt;
	logic hit_pending, hit_pending_nxt;
	logic [num_lines-1:0] valid_bits;

	logic [tag_bits-1:0] stored_tag;
	logic tag_wen;
	logic line_valid;
	logic hit;

	logic [word_bits-1:0] data_word;
	logic [strobe_width-1:0] data_wen;
	logic [data_width-1:0] data_wdata;
	logic [data_width-1:0] data_rdata;

	// request address fields
	assign req_tag = dreq_addr[offset_bits + index_bits +: tag_bits];
	assign req_index = dreq_addr[offset_bits +: index_bits];
	assign req_word = dreq_addr[align_bits +: word_bits];
	assign is_uncached = dreq_addr[addr_width-1 -: 4] != cached_region;

	// lookup against the zero latency tag read
	assign line_valid = valid_bits[req_index];
	assign hit = line_valid && stored_tag == req_tag;

	always_comb begin
		state_nxt = state;
		beat_nxt = beat;
		hit_pending_nxt = 1'b0;
		data_wen = '0;
		tag_wen = 1'b0;
		unique case (state)
			idle: begin
				if (hit_pending) begin
					// second hit cycle, data ram output is valid now
					data_wen = dreq_strobe;
				end else if (dreq_valid) begin
					if (is_uncached) begin
						state_nxt = uncached;
					end else if (hit) begin
						hit_pending_nxt = 1'b1;
					end else if (line_valid) begin
						// no dirty bit, so any valid victim goes back
						state_nxt = writeback;
					end else begin
						state_nxt = fetch;
					end
				end
			end
			writeback: begin
				if (cresp_ready) begin
					beat_nxt = beat + 1'b1;
					if (cresp_last) begin
						beat_nxt = '0;
						state_nxt = fetch;
					end
				end
			end
			fetch: begin
				if (cresp_ready) begin
					data_wen = '1;
					beat_nxt = beat + 1'b1;
					if (cresp_last) begin
						// line complete, tag and valid go in together
						beat_nxt = '0;
						tag_wen = 1'b1;
						state_nxt = idle;
					end
				end
			end
			uncached: begin
				if (cresp_ready) begin
					state_nxt = idle;
				end
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			beat <= '0;
			hit_pending <= 1'b0;
			valid_bits <= '0;
		end else begin
			state <= state_nxt;
			beat <= beat_nxt;
			hit_pending <= hit_pending_nxt;
			if (tag_wen) begin
				valid_bits[req_index] <= 1'b1;
			end
		end
	end

	// data ram word select
	// writeback reads one beat ahead so creq_data is ready on each beat
	always_comb begin
		unique case (state)
			writeback: data_word = beat_nxt;
			fetch: data_word = beat;
			uncached: data_word = req_word;
			idle: data_word = (state_nxt == writeback) ? beat_nxt : req_word;
		endcase
	end

	// refill data or cpu store data
	assign data_wdata = (state == fetch) ? cresp_data : dreq_data;

	sp_ram #(
		.addr_bits(index_bits),
		.data_bits(tag_bits),
		.read_latency(0)
	) tag_ram (
		.clk,
		.addr(req_index),
		.wen(tag_wen),
		.wdata(req_tag),
		.rdata(stored_tag)
	);

	sp_ram #(
		.addr_bits(index_bits + word_bits),
		.data_bits(data_width),
		.read_latency(1)
	) data_ram (
		.clk,
		.addr({req_index, data_word}),
		.wen(data_wen),
		.wdata(data_wdata),
		.rdata(data_rdata)
	);

	// cpu response
	// uncached finishes on the ready beat, hits one cycle after lookup
	assign dresp_data_ok = hit_pending || (state == uncached && cresp_ready);
	assign dresp_data = (state == uncached) ? cresp_data : data_rdata;

	// memory request
	assign creq_valid = state != idle;
	assign creq_is_write = state == writeback || (state == uncached && |dreq_strobe);
	// victim address rebuilt from the stored tag
	assign creq_addr = (state == uncached) ? dreq_addr :
		(state == writeback) ? {cached_region, stored_tag, req_index, {offset_bits{1'b0}}} :
		{dreq_addr[addr_width-1:offset_bits], {offset_bits{1'b0}}};
	assign creq_len = (state == uncached) ? len_single : len_line;
	assign creq_strobe = (state == uncached) ? dreq_strobe : '1;
	assign creq_data = (state == uncached) ? dreq_data : data_rdata;

endmodule

// File: rtl/sp_ram.sv
`timescale 1ns/100ps

module sp_ram #(
	parameter int addr_bits = 4,
	parameter int data_bits = 64,
	parameter int read_latency = 1
) (
	input logic clk,
	input logic [addr_bits-1:0] addr,
	// one enable per byte, or a single lane when the word is not whole bytes
	input logic [(data_bits % 8 == 0 ? data_bits / 8 : 1)-1:0] wen,
	input logic [data_bits-1:0] wdata,
	output logic [data_bits-1:0] rdata
);
	logic [data_bits-1:0] mem [2**addr_bits];
	logic [data_bits-1:0] bit_mask;

	// contents start cleared
	initial begin
		for (int i = 0; i < 2 ** addr_bits; i++) begin
			mem[i] = '0;
		end
	end

	// spread lane enables over their bits
	always_comb begin
		for (int i = 0; i < data_bits; i++) begin
			bit_mask[i] = wen[i / (data_bits / $bits(wen))];
		end
	end

	// merge enabled lanes into the stored word
	always @(posedge clk) begin
		if (|wen) begin
			mem[addr] <= (mem[addr] & ~bit_mask) | (wdata & bit_mask);
		end
	end

	generate
		if (read_latency == 0) begin : g_comb_read
			assign rdata = mem[addr];
		end else begin : g_reg_read
			// old data on a read during write
			always_ff @(posedge clk) begin
				rdata <= mem[addr];
			end
		end
	endgenerate

endmodule

// File: rtl/dcache_pkg.sv
package dcache_pkg;

	// bus widths
	localparam int addr_width = 32;
	localparam int data_width = 64;
	localparam int strobe_width = data_width / 8;

	// address split, tag | index | word | byte
	localparam int align_bits = 3;
	localparam int word_bits = 2;
	localparam int index_bits = 4;
	localparam int offset_bits = align_bits + word_bits;
	// top nibble selects the region, so it is not part of the tag
	localparam int tag_bits = addr_width - 4 - index_bits - offset_bits;

	// cache geometry, 16 lines of 4 words
	localparam int num_lines = 2 ** index_bits;
	localparam int words_per_line = 2 ** word_bits;

	// top nibble of a cacheable address
	localparam logic [3:0] cached_region = 4'h8;

	// burst lengths in beats
	localparam int len_width = 3;
	localparam logic [len_width-1:0] len_line = len_width'(words_per_line);
	localparam logic [len_width-1:0] len_single = 3'd1;

	// backing store, 512 words of 8 bytes
	localparam int mem_word_bits = 9;

	// cache controller states
	typedef enum logic [1:0] {
		idle,
		fetch,
		writeback,
		uncached
	} cache_state_t;

endpackage
